// ==== Makefile ====
# Verilator flow for the two stage binary32 fpu

TOP := fpu_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f project.f

# pass is decided by the log, not by the simulator exit status
sim:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "^TESTBENCH PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== project.f ====
common/fpu_pkg.sv
logic/fp_unpack.sv
addsub/fp_addsub_align.sv
addsub/fp_addsub_norm.sv
logic/fp_mul.sv
logic/fpu_core.sv
testbench/fpu_clock_gen.sv
testbench/fpu_tb.sv

// ==== testbench/fpu_tb.sv ====
// ------------------------------
// fpu_tb
// random and directed checks of the pipelined fpu against a real model
// ------------------------------

`timescale 1ns/1ps

module fpu_tb;

  import fpu_pkg::*;

  localparam int N_RAND     = 600;  // per operation
  localparam int N_DIRECT   = 37;   // special value cases
  localparam int N_SUBN     = 40;
  localparam int N_OPS      = 3 * N_RAND + N_DIRECT + N_SUBN;
  localparam int MAX_CYCLES = 2 * N_OPS + 200;

  logic     clk;
  logic     rst;
  logic     in_valid;
  fp_word_t a;
  fp_word_t b;
  e_fpu_op  op;
  logic     out_valid;
  fp_word_t result;

  int seed;
  int cycle;        // rising edges since start
  int checked;
  int value_errs;
  int proto_errs;   // latency, stray pulses, reset state

  fp_word_t exp_q[$];    // expected results in issue order
  string    name_q[$];
  int       stamp_q[$];  // edge index of each issue

  fpu_clock_gen clock_gen_inst (.clk(clk));

  fpu_core fpu_core_inst (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .a         (a),
    .b         (b),
    .op        (op),
    .out_valid (out_valid),
    .result    (result)
  );

  // binary32 normal to real through the double encoding
  function automatic real to_real(input fp_word_t w);
    logic [10:0] e;
    e = 11'(w.exp) + 11'd896;  // rebias 127 to 1023
    return $bitstoreal({w.sign, e, w.frac, 29'd0});
  endfunction

  // double to binary32 nearest even within the normal range
  function automatic fp_word_t round_to_single(input real r);
    logic [63:0] d;
    int          e;
    logic [30:0] mag;
    d = $realtobits(r);
    if (d[62:0] == '0) begin
      return '0;  // exact zero is +0
    end
    e   = int'(d[62:52]) - 1023 + EXP_BIAS;
    mag = {e[7:0], d[51:29]};
    if (d[28] && (|d[27:0] || d[29])) begin
      mag = mag + 31'd1;  // carry out of the fraction bumps the exponent
    end
    return {d[63], mag};
  endfunction

  function automatic fp_word_t expected_arith(input e_fpu_op o, input fp_word_t x,
                                              input fp_word_t y);
    real r;
    case (o)
      op_add:  r = to_real(x) + to_real(y);
      op_sub:  r = to_real(x) - to_real(y);
      default: r = to_real(x) * to_real(y);  // 48 bit product is exact in double
    endcase
    return round_to_single(r);
  endfunction

  function automatic fp_word_t rand_normal();
    int       r1;
    int       r2;
    fp_word_t w;
    r1 = $random(seed);
    r2 = $random(seed);
    w.sign = r1[31];
    w.exp  = 8'(100 + r1[15:0] % 55);  // 100..154
    w.frac = r2[22:0];
    return w;
  endfunction

  task automatic issue_op(input string name, input e_fpu_op o, input fp_word_t x,
                          input fp_word_t y, input fp_word_t exp_w);
    @(posedge clk);
    in_valid <= 1'b1;
    op       <= o;
    a        <= x;
    b        <= y;
    exp_q.push_back(exp_w);
    name_q.push_back(name);
    stamp_q.push_back(cycle + 1);  // counter still holds the previous edge
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      in_valid <= 1'b0;
    end
  endtask

  task automatic reset_dut();
    rst <= 1'b1;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    if (out_valid !== 1'b0) begin
      $display("out_valid is not low after reset");
      proto_errs++;
    end
  endtask

  task automatic run_random(input e_fpu_op o, input string name);
    int       r;
    fp_word_t x;
    fp_word_t y;
    for (int i = 0; i < N_RAND; i++) begin
      r = $random(seed);
      if (r[1:0] == 2'b00) begin
        idle_cycles(int'(r[3:2]) + 1);  // gap of 1..4 cycles
      end
      x = rand_normal();
      if (o != op_mul && r[6:4] == 3'b000) begin
        // same exponent and near equal magnitude, so the sum cancels
        y      = x;
        y.sign = x.sign ^ (o == op_add);
        y.frac = x.frac ^ 23'(r[11:7]);
      end else begin
        y = rand_normal();
      end
      issue_op(name, o, x, y, expected_arith(o, x, y));
    end
  endtask

  task automatic run_specials();
    int       r;
    fp_word_t x;
    fp_word_t y;
    fp_word_t z;
    // nan passthrough with a before b
    issue_op("nan_a", op_add, 32'h7f81_2345, 32'h3f80_0000, 32'h7f81_2345);
    issue_op("nan_b", op_sub, 32'h3f80_0000, 32'hffc0_0001, 32'hffc0_0001);
    issue_op("nan_both", op_mul, 32'h7fa0_0000, 32'h7fc0_0abc, 32'h7fa0_0000);
    issue_op("nan_b_mul", op_mul, 32'h4000_0000, 32'h7f80_0001, 32'h7f80_0001);
    issue_op("nan_over_inf", op_add, 32'h7f80_0000, 32'h7fc0_0005, 32'h7fc0_0005);
    // invalid operations
    issue_op("inf_sub", op_sub, 32'h7f80_0000, 32'h7f80_0000, QNAN_WORD);
    issue_op("ninf_sub", op_sub, 32'hff80_0000, 32'hff80_0000, QNAN_WORD);
    issue_op("inf_add_opp", op_add, 32'h7f80_0000, 32'hff80_0000, QNAN_WORD);
    issue_op("zero_inf", op_mul, 32'h0000_0000, 32'h7f80_0000, QNAN_WORD);
    issue_op("inf_zero", op_mul, 32'hff80_0000, 32'h8000_0000, QNAN_WORD);
    // infinities with finite partners
    issue_op("inf_add", op_add, 32'h7f80_0000, 32'h3f80_0000, 32'h7f80_0000);
    issue_op("inf_rsub", op_sub, 32'h3f80_0000, 32'h7f80_0000, 32'hff80_0000);
    issue_op("inf_mul", op_mul, 32'hff80_0000, 32'hc000_0000, 32'h7f80_0000);
    for (int i = 0; i < 8; i++) begin
      x      = rand_normal();
      y      = x;
      y.sign = ~x.sign;
      issue_op("self_sub", op_sub, x, x, 32'h0000_0000);
      issue_op("neg_add", op_add, x, y, 32'h0000_0000);
    end
    for (int i = 0; i < 8; i++) begin
      x = rand_normal();
      r = $random(seed);
      z = {r[0], 31'd0};  // signed zero
      issue_op("zero_mul", op_mul, z, x, {r[0] ^ x.sign, 31'd0});
    end
  endtask

  task automatic run_subnormal_add();
    int          r1;
    int          r2;
    fp_word_t    x;
    fp_word_t    y;
    logic [31:0] sum_w;
    for (int i = 0; i < N_SUBN; i++) begin
      r1    = $random(seed);
      r2    = $random(seed);
      x     = {1'b0, 8'd0, r1[22:1], 1'b1};
      y     = {1'b0, 8'd0, r2[22:0] | 23'd1};
      sum_w = x + y;  // encodings add as integers even across into exponent 1
      issue_op("subn_add", op_add, x, y, sum_w);
    end
  endtask

  task automatic check_result();
    fp_word_t exp_w;
    string    name;
    int       stamp;
    exp_w = exp_q.pop_front();
    name  = name_q.pop_front();
    stamp = stamp_q.pop_front();
    checked++;
    if (cycle - stamp != 2) begin
      $display("%s result arrived %0d edges after issue, not 2", name, cycle - stamp);
      proto_errs++;
    end
    if (result !== exp_w) begin
      $display("ERR %s: expected %08h, actual %08h", name, exp_w, result);
      value_errs++;
    end
  endtask

  task automatic print_counts();
    $display("results checked %0d, value errors %0d, protocol errors %0d",
             checked, value_errs, proto_errs);
  endtask

  // outputs sampled mid cycle away from the driving edge
  always @(negedge clk) begin
    if (!rst && out_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("out_valid pulsed at cycle %0d with no operation pending", cycle);
        proto_errs++;
      end else begin
        check_result();
      end
    end
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= MAX_CYCLES) begin
      $display("timeout after %0d cycles with %0d results missing", cycle, exp_q.size());
      print_counts();
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  initial begin
    seed       = 32'hd6c9;
    cycle      = 0;
    checked    = 0;
    value_errs = 0;
    proto_errs = 0;
    rst        = 1'b1;
    in_valid   = 1'b0;
    a          = '0;
    b          = '0;
    op         = op_add;
    reset_dut();
    run_random(op_add, "rand_add");
    run_random(op_sub, "rand_sub");
    run_random(op_mul, "rand_mul");
    run_specials();
    run_subnormal_add();
    idle_cycles(1);
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (8) @(negedge clk);  // room for a stray pulse
    print_counts();
    if (value_errs == 0 && proto_errs == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== testbench/fpu_clock_gen.sv ====
// ------------------------------
// fpu_clock_gen
// free running 4 ns testbench clock
// ------------------------------

`timescale 1ns/1ps

module fpu_clock_gen (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // half period
  end

endmodule

// ==== logic/fpu_core.sv ====
// ------------------------------
// fpu_core
// two stage binary32 add, subtract and multiply unit
// ------------------------------

`timescale 1ns/1ps

module fpu_core (
  input  logic              clk,
  input  logic              rst,
  input  logic              in_valid,
  input  fpu_pkg::fp_word_t a,
  input  fpu_pkg::fp_word_t b,
  input  fpu_pkg::e_fpu_op  op,
  output logic              out_valid,
  output fpu_pkg::fp_word_t result
);

  import fpu_pkg::*;

  logic         s1_valid;   // stage 1 holds an operation
  fp_word_t     s1_a;
  fp_word_t     s1_b;
  e_fpu_op      s1_op;
  fp_unpacked_t a_unp;
  fp_unpacked_t b_unp;
  addsub_sum_t  addsub_sum;
  fp_word_t     addsub_res;
  fp_word_t     mul_res;
  fp_word_t     sel_res;
  logic         subtract;

  // valid pipeline
  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      s1_valid  <= in_valid;
      out_valid <= s1_valid;
    end
  end

  // operand capture
  always_ff @(posedge clk) begin
    if (in_valid) begin
      s1_a  <= a;
      s1_b  <= b;
      s1_op <= op;
    end
  end

  fp_unpack unpack_a_inst (.word(s1_a), .unpacked(a_unp));
  fp_unpack unpack_b_inst (.word(s1_b), .unpacked(b_unp));

  assign subtract = (s1_op == op_sub);

  fp_addsub_align align_inst (
    .a        (a_unp),
    .b        (b_unp),
    .subtract (subtract),
    .sum      (addsub_sum)
  );

  fp_addsub_norm norm_inst (
    .sum      (addsub_sum),
    .a        (a_unp),
    .b        (b_unp),
    .subtract (subtract),
    .result   (addsub_res)
  );

  fp_mul mul_inst (.a(a_unp), .b(b_unp), .result(mul_res));

  assign sel_res = (s1_op == op_mul) ? mul_res : addsub_res;

  // result holds between valid pulses
  always_ff @(posedge clk) begin
    if (s1_valid) begin
      result <= sel_res;
    end
  end

  a_op_legal : assert property (@(posedge clk) disable iff (rst)
    in_valid |-> (op inside {op_add, op_sub, op_mul}))
    else $error("illegal opcode issued");

  // two edges from issue to result once reset has cleared the pipe
  a_valid_latency : assert property (@(posedge clk) disable iff (rst)
    (!$past(rst) && !$past(rst, 2)) |-> (out_valid == $past(in_valid, 2)))
    else $error("out_valid does not follow in_valid by two cycles");

endmodule

// ==== logic/fp_mul.sv ====
// ------------------------------
// fp_mul
// binary32 multiply with nearest even rounding
// ------------------------------

`timescale 1ns/1ps

module fp_mul (
  input  fpu_pkg::fp_unpacked_t a,
  input  fpu_pkg::fp_unpacked_t b,
  output fpu_pkg::fp_word_t     result
);

  import fpu_pkg::*;

  localparam int PROD_W = 2 * SIG_W;

  logic [PROD_W-1:0] product;    // 2 integer bits above the fraction
  logic              prod_hi;    // product in [2,4)
  logic [PROD_W-1:0] prod_n;     // leading one at the msb
  logic [EXP_W-1:0]  exp_sum;
  logic [EXP_W-1:0]  exp_n;
  logic              guard;
  logic              sticky;
  logic              lsb;
  logic              round_up;
  logic [SIG_W:0]    rounded;    // one extra bit for the rounding carry
  logic [SIG_W:0]    sig_r;
  logic [EXP_W-1:0]  exp_r;
  logic              sign_r;
  logic              zero_inf;   // zero times infinity in either order

  assign product = PROD_W'(a.sig) * PROD_W'(b.sig);
  assign exp_sum = a.exp + b.exp - EXP_W'(EXP_BIAS);

  assign prod_hi = product[PROD_W-1];
  assign exp_n   = prod_hi ? (exp_sum + EXP_W'(1)) : exp_sum;
  assign prod_n  = prod_hi ? product : (product << 1);

  // kept significand is the top SIG_W bits
  assign lsb      = prod_n[PROD_W-SIG_W];
  assign guard    = prod_n[PROD_W-SIG_W-1];
  assign sticky   = |prod_n[PROD_W-SIG_W-2:0];
  assign round_up = guard && (sticky || lsb);  // ties go to even

  assign rounded = {1'b0, prod_n[PROD_W-1 -: SIG_W]} + (SIG_W+1)'(round_up);
  // 1.111..1 rounding up carries into 10.000..0
  assign sig_r   = rounded[SIG_W] ? (rounded >> 1) : rounded;
  assign exp_r   = exp_n + EXP_W'(rounded[SIG_W]);

  assign sign_r   = a.sign ^ b.sign;
  assign zero_inf = (a.is_zero && b.is_inf) || (a.is_inf && b.is_zero);

  always_comb begin
    if (a.is_nan) begin
      result = a.raw;
    end else if (b.is_nan) begin
      result = b.raw;
    end else if (zero_inf) begin
      result = QNAN_WORD;
    end else if (a.is_inf || b.is_inf) begin
      result = {sign_r, EXP_MAX, {MAN_W{1'b0}}};
    end else if (a.is_zero || b.is_zero) begin
      result = {sign_r, {EXP_W{1'b0}}, {MAN_W{1'b0}}};  // signed zero
    end else begin
      result = {sign_r, exp_r, sig_r[MAN_W-1:0]};
    end
  end

  // datapath exponent must never land on a nan encoding
  always_comb begin
    assert final (!(result.exp == EXP_MAX && result.frac != '0) ||
                  a.is_nan || b.is_nan || zero_inf)
      else $error("multiply produced nan from non-nan operands");
  end

endmodule

// ==== addsub/fp_addsub_norm.sv ====
// ------------------------------
// fp_addsub_norm
// normalizes and rounds the add/sub sum, resolves specials
// ------------------------------

`timescale 1ns/1ps

module fp_addsub_norm (
  input  fpu_pkg::addsub_sum_t  sum,
  input  fpu_pkg::fp_unpacked_t a,
  input  fpu_pkg::fp_unpacked_t b,
  input  logic                  subtract,
  output fpu_pkg::fp_word_t     result
);

  import fpu_pkg::*;

  localparam int RND_W  = ADD_W - GRS_W;       // significand plus sign and carry
  localparam int LZ_OFS = 32 - ADD_W + 2;      // pad bits plus sign and carry

  logic             neg;         // sign of the sum
  logic [ADD_W-1:0] mag;
  logic             carry;       // carry out of the significand
  logic [ADD_W-1:0] mag_c;
  logic [EXP_W-1:0] exp_c;
  logic [5:0]       zcount;
  logic [EXP_W-1:0] shift_amt;
  logic [EXP_W-1:0] exp_n;
  logic [ADD_W-1:0] mag_n;
  logic [ADD_W-1:0] mag_s;
  logic             round_up;
  logic [RND_W-1:0] rounded;
  logic             carry_r;
  logic [RND_W-1:0] sig_r;
  logic [EXP_W-1:0] exp_r;
  logic             b_sign_eff;  // b sign as seen by the adder
  logic             special;

  assign neg   = sum.sum[ADD_W-1];
  assign mag   = neg ? -sum.sum : sum.sum;
  assign carry = mag[ADD_W-2];
  assign mag_c = carry ? ((mag >> 1) | ADD_W'(mag[0])) : mag;  // lsb folds into sticky
  assign exp_c = sum.exp + EXP_W'(carry);

  // leading zeros below the sign and carry positions
  assign zcount = lzc32({{(32-ADD_W){1'b0}}, mag_c}) - 6'(LZ_OFS);

  // stop shifting at exponent 0 so tiny results go subnormal
  assign shift_amt = (EXP_W'(zcount) < exp_c) ? EXP_W'(zcount) : exp_c;
  assign exp_n     = exp_c - shift_amt;
  assign mag_n     = mag_c << shift_amt;
  // exponent 0 encodes 2^-126 with no hidden bit, so drop one position
  assign mag_s     = (exp_n == '0) ? (mag_n >> 1) : mag_n;

  // nearest even from guard, round, sticky and the lsb
  assign round_up = mag_s[GRS_W-1] && (|mag_s[GRS_W-2:0] || mag_s[GRS_W]);
  assign rounded  = mag_s[ADD_W-1:GRS_W] + RND_W'(round_up);
  assign carry_r  = rounded[SIG_W];
  assign sig_r    = carry_r ? (rounded >> 1) : rounded;

  always_comb begin
    if (carry_r) begin
      exp_r = exp_n + EXP_W'(1);
    end else if (exp_n == '0 && rounded[MAN_W]) begin
      exp_r = EXP_W'(1);  // subnormal rounded up to the smallest normal
    end else begin
      exp_r = exp_n;
    end
  end

  assign b_sign_eff = b.sign ^ subtract;
  assign special    = a.is_nan || b.is_nan || a.is_inf || b.is_inf;

  always_comb begin
    if (a.is_nan) begin
      result = a.raw;
    end else if (b.is_nan) begin
      result = b.raw;
    end else if (a.is_inf && b.is_inf && (a.sign != b_sign_eff)) begin
      result = QNAN_WORD;                     // inf - inf
    end else if (a.is_inf) begin
      result = {a.sign, EXP_MAX, {MAN_W{1'b0}}};
    end else if (b.is_inf) begin
      result = {b_sign_eff, EXP_MAX, {MAN_W{1'b0}}};
    end else if (sig_r == '0) begin
      result = '0;                            // exact cancellation is +0
    end else begin
      result = {neg, exp_r, sig_r[MAN_W-1:0]};
    end
  end

  // finite nonzero results are normalized or encoded subnormal
  always_comb begin
    assert final (special || sig_r == '0 || sig_r[MAN_W] || exp_r == '0)
      else $error("add/sub result lost its hidden bit at exponent %0d", exp_r);
  end

endmodule

// ==== addsub/fp_addsub_align.sv ====
// ------------------------------
// fp_addsub_align
// aligns two operands and forms their signed sum
// ------------------------------

`timescale 1ns/1ps

module fp_addsub_align (
  input  fpu_pkg::fp_unpacked_t a,
  input  fpu_pkg::fp_unpacked_t b,
  input  logic                  subtract,
  output fpu_pkg::addsub_sum_t  sum
);

  import fpu_pkg::*;

  // smaller operand before the sticky bit is appended
  localparam int EXT_W = ADD_W - 1;

  logic             a_small;     // a has the smaller exponent
  logic [EXP_W-1:0] exp_diff;    // absolute exponent difference
  logic [SIG_W-1:0] small_sig;
  logic [SIG_W-1:0] big_sig;
  logic [EXT_W-1:0] small_ext;   // 2 upper bits, significand, guard and round
  logic [EXT_W-1:0] shift_mask;  // bits that fall off the bottom
  logic             sticky;
  logic [ADD_W-1:0] small_al;
  logic [ADD_W-1:0] big_al;
  logic [ADD_W-1:0] a_al;
  logic [ADD_W-1:0] b_al;
  logic [ADD_W-1:0] a_sgn;       // two's complement by operand sign
  logic [ADD_W-1:0] b_sgn;

  assign a_small  = (a.exp < b.exp);
  assign exp_diff = a_small ? (b.exp - a.exp) : (a.exp - b.exp);

  // on equal exponents b takes the small path with a zero shift
  assign small_sig = a_small ? a.sig : b.sig;
  assign big_sig   = a_small ? b.sig : a.sig;

  assign small_ext  = {2'b00, small_sig, {(GRS_W-1){1'b0}}};
  assign shift_mask = ~({EXT_W{1'b1}} << exp_diff);  // low exp_diff bits set
  assign sticky     = |(small_ext & shift_mask);     // or of everything shifted out

  assign small_al = {small_ext >> exp_diff, sticky};
  assign big_al   = {2'b00, big_sig, {GRS_W{1'b0}}};

  // put the aligned values back on their own operand
  assign a_al = a_small ? small_al : big_al;
  assign b_al = a_small ? big_al   : small_al;

  assign a_sgn = a.sign ? -a_al : a_al;
  assign b_sgn = b.sign ? -b_al : b_al;

  always_comb begin
    // sign lands in the msb, carry one below it
    if (subtract) begin
      sum.sum = a_sgn - b_sgn;
    end else begin
      sum.sum = a_sgn + b_sgn;
    end
    sum.exp = a_small ? b.exp : a.exp;  // result exponent before normalization
  end

endmodule

// ==== logic/fp_unpack.sv ====
// ------------------------------
// fp_unpack
// classifies a binary32 operand and expands its significand
// ------------------------------

`timescale 1ns/1ps

module fp_unpack (
  input  fpu_pkg::fp_word_t     word,
  output fpu_pkg::fp_unpacked_t unpacked
);

  import fpu_pkg::*;

  logic exp_zero;   // exponent field all zero
  logic exp_ones;   // exponent field all ones
  logic frac_zero;

  assign exp_zero  = (word.exp == '0);
  assign exp_ones  = (word.exp == EXP_MAX);
  assign frac_zero = (word.frac == '0);

  always_comb begin
    unpacked.sign    = word.sign;

    // classification from the two fields
    unpacked.is_zero = exp_zero && frac_zero;
    unpacked.is_sub  = exp_zero && !frac_zero;
    unpacked.is_inf  = exp_ones && frac_zero;
    unpacked.is_nan  = exp_ones && !frac_zero;

    // subnormals live at the minimum normal exponent
    // zero keeps its field value of 0
    if (unpacked.is_sub) begin
      unpacked.exp = EXP_W'(1);
    end else begin
      unpacked.exp = word.exp;
    end

    // hidden bit only for nonzero normals, 0.frac for subnormal and zero
    unpacked.sig = {!exp_zero, word.frac};

    unpacked.raw = word;  // original word for nan passthrough
  end

endmodule

// ==== common/fpu_pkg.sv ====
// ------------------------------
// fpu_pkg
// binary32 format constants, opcodes and datapath structs
// ------------------------------

package fpu_pkg;

  // binary32 field widths
  localparam int EXP_W    = 8;
  localparam int MAN_W    = 23;             // stored fraction
  localparam int SIG_W    = MAN_W + 1;      // with hidden bit
  localparam int EXP_BIAS = 127;

  localparam logic [EXP_W-1:0] EXP_MAX = '1; // inf or nan

  // guard, round and sticky below the significand
  localparam int GRS_W = 3;

  // signed add/sub significand
  // 2 upper bits hold sign and carry, then significand, then grs
  localparam int ADD_W = 2 + SIG_W + GRS_W;

  typedef enum logic [1:0] {
    op_add = 2'b00,
    op_sub = 2'b01,
    op_mul = 2'b10  // 2'b11 is illegal
  } e_fpu_op;

  typedef struct packed {
    logic             sign;
    logic [EXP_W-1:0] exp;
    logic [MAN_W-1:0] frac;
  } fp_word_t;

  // canonical quiet nan, fraction msb set
  localparam fp_word_t QNAN_WORD = 32'h7fc0_0000;

  typedef struct packed {
    logic             sign;
    logic [EXP_W-1:0] exp;     // effective exponent, 1 for subnormals
    logic [SIG_W-1:0] sig;     // hidden bit included
    logic             is_nan;
    logic             is_inf;
    logic             is_zero;
    logic             is_sub;
    fp_word_t         raw;     // kept for nan propagation
  } fp_unpacked_t;

  // align stage to norm stage
  typedef struct packed {
    logic [ADD_W-1:0] sum;     // two's complement significand sum
    logic [EXP_W-1:0] exp;     // larger operand exponent
  } addsub_sum_t;

  // leading zero count of a 32 bit word, 32 when all zero
  function automatic logic [5:0] lzc32(input logic [31:0] x);
    logic [5:0] cnt;
    cnt = 6'd32;
    // last hit wins, so the highest set bit decides
    for (int i = 0; i < 32; i++) begin
      if (x[i]) begin
        cnt = 6'(31 - i);
      end
    end
    return cnt;
  endfunction

endpackage
